/* flist.f */
src/cnt_pkg.sv
src/cnt_apb_regs.sv
src/cnt_channel.sv
src/cnt_intr_ctrl.sv
src/cnt_top.sv
verification/tb_clk_gen.sv
verification/tb_cnt_checker.sv
verification/tb_cnt_top.sv

/* src/cnt_apb_regs.sv */
`timescale 1ns/1ps

module cnt_apb_regs (
  input  logic                             i_pclk,
  input  logic                             i_prst_n,
  // apb slave, no wait states
  input  logic [cnt_pkg::ADDR_W-1:0]       i_paddr,
  input  logic [cnt_pkg::DATA_W-1:0]       i_pwdata,
  input  logic                             i_pwrite,
  input  logic                             i_psel,
  input  logic                             i_penable,
  output logic [cnt_pkg::DATA_W-1:0]       o_prdata,
  // toward the channels
  output cnt_pkg::cnt_cmd_e                o_ch_cmd    [cnt_pkg::COUNTER_NUM],
  output cnt_pkg::cnt_mode_e               o_ch_mode   [cnt_pkg::COUNTER_NUM],
  output logic [cnt_pkg::CNT_W-1:0]        o_ch_target [cnt_pkg::COUNTER_NUM],
  // from the channels
  input  logic [cnt_pkg::CNT_W-1:0]        i_ch_count  [cnt_pkg::COUNTER_NUM],
  input  cnt_pkg::ch_state_e               i_ch_state  [cnt_pkg::COUNTER_NUM],
  // interrupt controller
  input  logic [cnt_pkg::COUNTER_NUM-1:0]  i_intr_status,
  output logic [cnt_pkg::COUNTER_NUM-1:0]  o_intr_mask,
  output logic                             o_status_clr_wr,
  output logic [cnt_pkg::COUNTER_NUM-1:0]  o_status_clr_data
);
  import cnt_pkg::*;

  logic             wr_en;
  logic             rd_en;
  cnt_cmd_e         glb_cmd;
  cnt_cmd_e         cmd_nxt [COUNTER_NUM];
  logic [DATA_W-1:0] rdata_nxt;

  // everything happens at the edge that ends the setup phase
  assign wr_en = i_psel && i_pwrite && !i_penable;
  assign rd_en = i_psel && !i_pwrite && !i_penable;

  // global command, only valid on a write to its address
  assign glb_cmd = (wr_en && i_paddr == ADDR_GLOBAL_CMD) ? cnt_cmd_e'(i_pwdata[1:0]) : CMD_NONE;

  // per-channel command, global overrides
  always_comb begin
    for (int n = 0; n < COUNTER_NUM; n++) begin
      cmd_nxt[n] = CMD_NONE;
      if (wr_en && i_paddr == ch_addr(n, OFS_CMD)) begin
        cmd_nxt[n] = cnt_cmd_e'(i_pwdata[1:0]);
      end
      if (glb_cmd != CMD_NONE) begin
        cmd_nxt[n] = glb_cmd;
      end
    end
  end

  // command pulses last exactly one cycle
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      for (int n = 0; n < COUNTER_NUM; n++) begin
        o_ch_cmd[n] <= CMD_NONE;
      end
    end else begin
      for (int n = 0; n < COUNTER_NUM; n++) begin
        o_ch_cmd[n] <= cmd_nxt[n];
      end
    end
  end

  // mode and target per channel
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      for (int n = 0; n < COUNTER_NUM; n++) begin
        o_ch_mode[n]   <= MODE_ONESHOT;
        o_ch_target[n] <= '0;
      end
    end else if (wr_en) begin
      for (int n = 0; n < COUNTER_NUM; n++) begin
        if (i_paddr == ch_addr(n, OFS_CTRL)) begin
          o_ch_mode[n] <= cnt_mode_e'(i_pwdata[CTRL_MODE_BIT]);
        end
        if (i_paddr == ch_addr(n, OFS_TARGET)) begin
          o_ch_target[n] <= i_pwdata[CNT_W-1:0];
        end
      end
    end
  end

  // interrupt mask, all channels disabled out of reset
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      o_intr_mask <= '0;
    end else if (wr_en && i_paddr == ADDR_INTR_MASK) begin
      o_intr_mask <= i_pwdata[COUNTER_NUM-1:0];
    end
  end

  // w1c strobe goes straight to the status bits
  assign o_status_clr_wr   = wr_en && (i_paddr == ADDR_INTR_STATUS);
  assign o_status_clr_data = i_pwdata[COUNTER_NUM-1:0];

  // read mux, unmapped addresses read 0
  always_comb begin
    rdata_nxt = '0;
    if (i_paddr == ADDR_INTR_STATUS) begin
      rdata_nxt[COUNTER_NUM-1:0] = i_intr_status;
    end
    if (i_paddr == ADDR_INTR_MASK) begin
      rdata_nxt[COUNTER_NUM-1:0] = o_intr_mask;
    end
    for (int n = 0; n < COUNTER_NUM; n++) begin
      if (i_paddr == ch_addr(n, OFS_CTRL)) begin
        rdata_nxt[CTRL_MODE_BIT]       = o_ch_mode[n];
        rdata_nxt[CTRL_STATE_LSB +: 2] = i_ch_state[n];
      end
      if (i_paddr == ch_addr(n, OFS_TARGET)) begin
        rdata_nxt[CNT_W-1:0] = o_ch_target[n];
      end
      if (i_paddr == ch_addr(n, OFS_COUNT)) begin
        rdata_nxt[CNT_W-1:0] = i_ch_count[n];
      end
    end
  end

  // read data sampled in setup, held until the next read
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      o_prdata <= '0;
    end else if (rd_en) begin
      o_prdata <= rdata_nxt;
    end
  end

  // bus protocol: access phase only right after a setup phase to the same address
  ap_access_after_setup: assert property (
    @(posedge i_pclk) disable iff (!i_prst_n)
    (i_psel && i_penable) |-> $past(i_psel && !i_penable) && $stable(i_paddr)
  );

endmodule

/* src/cnt_channel.sv */
`timescale 1ns/1ps

module cnt_channel (
  input  logic                       i_pclk,
  input  logic                       i_prst_n,
  input  cnt_pkg::cnt_cmd_e          i_cmd,
  input  cnt_pkg::cnt_mode_e         i_mode,
  input  logic [cnt_pkg::CNT_W-1:0]  i_target,
  output logic [cnt_pkg::CNT_W-1:0]  o_count,
  output cnt_pkg::ch_state_e         o_state,
  output logic                       o_match,
  output logic                       o_wave
);
  import cnt_pkg::*;

  ch_state_e        state_q;
  ch_state_e        state_nxt;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_nxt;
  logic             wave_q;

  // match only counts while running
  assign o_match = (state_q == ST_RUN) && (count_q == i_target);

  // commands take priority over the match in the run fsm
  always_comb begin
    state_nxt = state_q;
    unique case (i_cmd)
      CMD_START: state_nxt = ST_RUN;
      CMD_STOP:  state_nxt = ST_IDLE;
      CMD_CLEAR: state_nxt = state_q;
      CMD_NONE: begin
        // one-shot stops at the target
        if (o_match && i_mode == MODE_ONESHOT) begin
          state_nxt = ST_DONE;
        end
      end
    endcase
  end

  // counter datapath
  always_comb begin
    count_nxt = count_q;
    if (i_cmd == CMD_CLEAR) begin
      count_nxt = '0;
    end else if (state_q == ST_RUN && i_cmd != CMD_STOP) begin
      if (o_match) begin
        // periodic wraps to 0 while one-shot holds the target
        count_nxt = (i_mode == MODE_PERIODIC) ? '0 : count_q;
      end else begin
        count_nxt = count_q + CNT_W'(1);
      end
    end
  end

  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      state_q <= ST_IDLE;
      count_q <= '0;
    end else begin
      state_q <= state_nxt;
      count_q <= count_nxt;
    end
  end

  // wave flips once per match
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      wave_q <= 1'b0;
    end else if (o_match) begin
      wave_q <= ~wave_q;
    end
  end

  assign o_count = count_q;
  assign o_state = state_q;
  assign o_wave  = wave_q;

  // one-shot halts in done with the count parked on the target
  ap_oneshot_halt: assert property (
    @(posedge i_pclk) disable iff (!i_prst_n)
    (o_match && i_mode == MODE_ONESHOT && i_cmd == CMD_NONE) |=>
      (o_state == ST_DONE) && (o_count == $past(i_target))
  );

endmodule

/* src/cnt_intr_ctrl.sv */
`timescale 1ns/1ps

module cnt_intr_ctrl (
  input  logic                             i_pclk,
  input  logic                             i_prst_n,
  input  logic [cnt_pkg::COUNTER_NUM-1:0]  i_match,
  input  logic                             i_clr_wr,
  input  logic [cnt_pkg::COUNTER_NUM-1:0]  i_clr_data,
  input  logic [cnt_pkg::COUNTER_NUM-1:0]  i_mask,
  output logic [cnt_pkg::COUNTER_NUM-1:0]  o_status,
  output logic                             o_int
);
  import cnt_pkg::*;

  logic [COUNTER_NUM-1:0] status_q;
  logic [COUNTER_NUM-1:0] clr_vec;

  // clear vector only on a status write
  assign clr_vec = i_clr_wr ? i_clr_data : '0;

  // a new match beats a clear in the same cycle
  always_ff @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~clr_vec) | i_match;
    end
  end

  assign o_status = status_q;

  // level interrupt straight from status and mask
  assign o_int = |(status_q & i_mask);

  // a status bit only falls on a status write
  ap_clear_needs_write: assert property (
    @(posedge i_pclk) disable iff (!i_prst_n)
    (|($past(o_status) & ~o_status)) |-> $past(i_clr_wr)
  );

  // interrupt rises only after a match or a mask write
  ap_int_cause: assert property (
    @(posedge i_pclk) disable iff (!i_prst_n)
    $rose(o_int) |-> ($past(|i_match) || $changed(i_mask))
  );

endmodule

/* src/cnt_pkg.sv */
package cnt_pkg;

  // channel count and bus widths
  localparam int COUNTER_NUM = 4;
  localparam int CNT_W       = 32;
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;

  // global registers
  localparam logic [ADDR_W-1:0] ADDR_GLOBAL_CMD  = 32'h00;
  localparam logic [ADDR_W-1:0] ADDR_INTR_STATUS = 32'h04;
  localparam logic [ADDR_W-1:0] ADDR_INTR_MASK   = 32'h08;

  // channel blocks start here, one block per channel
  localparam logic [ADDR_W-1:0] CH_BASE   = 32'h10;
  localparam logic [ADDR_W-1:0] CH_STRIDE = 32'h10;

  // offsets inside a channel block
  localparam logic [ADDR_W-1:0] OFS_CTRL   = 32'h0;
  localparam logic [ADDR_W-1:0] OFS_TARGET = 32'h4;
  localparam logic [ADDR_W-1:0] OFS_COUNT  = 32'h8;
  localparam logic [ADDR_W-1:0] OFS_CMD    = 32'hC;

  // ctrl register fields
  localparam int CTRL_MODE_BIT  = 0;
  localparam int CTRL_STATE_LSB = 8;

  // command code, bits 1:0 of a command write
  typedef enum logic [1:0] {
    CMD_NONE  = 2'd0,
    CMD_START = 2'd1,
    CMD_STOP  = 2'd2,
    CMD_CLEAR = 2'd3
  } cnt_cmd_e;

  typedef enum logic {
    MODE_ONESHOT  = 1'b0,
    MODE_PERIODIC = 1'b1
  } cnt_mode_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RUN  = 2'd1,
    ST_DONE = 2'd2
  } ch_state_e;

  // address of one register in the block of channel ch
  function automatic logic [ADDR_W-1:0] ch_addr(input int ch, input logic [ADDR_W-1:0] ofs);
    ch_addr = CH_BASE + ADDR_W'(ch) * CH_STRIDE + ofs;
  endfunction

endpackage

/* src/cnt_top.sv */
`timescale 1ns/1ps

module cnt_top (
  input  logic                             i_pclk,
  input  logic                             i_prst_n,
  input  logic [cnt_pkg::ADDR_W-1:0]       i_paddr,
  input  logic [cnt_pkg::DATA_W-1:0]       i_pwdata,
  input  logic                             i_pwrite,
  input  logic                             i_psel,
  input  logic                             i_penable,
  output logic [cnt_pkg::DATA_W-1:0]       o_prdata,
  output logic [cnt_pkg::COUNTER_NUM-1:0]  o_wave,
  output logic                             o_int
);
  import cnt_pkg::*;

  // register bank to channels
  cnt_cmd_e               ch_cmd    [COUNTER_NUM];
  cnt_mode_e              ch_mode   [COUNTER_NUM];
  logic [CNT_W-1:0]       ch_target [COUNTER_NUM];
  // channels back to register bank
  logic [CNT_W-1:0]       ch_count  [COUNTER_NUM];
  ch_state_e              ch_state  [COUNTER_NUM];
  // match events and interrupt path
  logic [COUNTER_NUM-1:0] ch_match;
  logic [COUNTER_NUM-1:0] intr_status;
  logic [COUNTER_NUM-1:0] intr_mask;
  logic                   status_clr_wr;
  logic [COUNTER_NUM-1:0] status_clr_data;

  cnt_apb_regs u_regs (
    .i_pclk            (i_pclk),
    .i_prst_n          (i_prst_n),
    .i_paddr           (i_paddr),
    .i_pwdata          (i_pwdata),
    .i_pwrite          (i_pwrite),
    .i_psel            (i_psel),
    .i_penable         (i_penable),
    .o_prdata          (o_prdata),
    .o_ch_cmd          (ch_cmd),
    .o_ch_mode         (ch_mode),
    .o_ch_target       (ch_target),
    .i_ch_count        (ch_count),
    .i_ch_state        (ch_state),
    .i_intr_status     (intr_status),
    .o_intr_mask       (intr_mask),
    .o_status_clr_wr   (status_clr_wr),
    .o_status_clr_data (status_clr_data)
  );

  // one counter per channel
  for (genvar i = 0; i < COUNTER_NUM; i++) begin : g_ch
    cnt_channel u_ch (
      .i_pclk   (i_pclk),
      .i_prst_n (i_prst_n),
      .i_cmd    (ch_cmd[i]),
      .i_mode   (ch_mode[i]),
      .i_target (ch_target[i]),
      .o_count  (ch_count[i]),
      .o_state  (ch_state[i]),
      .o_match  (ch_match[i]),
      .o_wave   (o_wave[i])
    );
  end

  cnt_intr_ctrl u_intr (
    .i_pclk     (i_pclk),
    .i_prst_n   (i_prst_n),
    .i_match    (ch_match),
    .i_clr_wr   (status_clr_wr),
    .i_clr_data (status_clr_data),
    .i_mask     (intr_mask),
    .o_status   (intr_status),
    .o_int      (o_int)
  );

endmodule

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  // 4 ns period
  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;
  end

  // reset held low for three rising edges
  initial begin
    o_rst_n = 1'b0;
    repeat (3) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

/* verification/tb_cnt_checker.sv */
`timescale 1ns/1ps

module tb_cnt_checker (
  input logic                             i_pclk,
  input logic                             i_prst_n,
  input logic [cnt_pkg::ADDR_W-1:0]       i_paddr,
  input logic [cnt_pkg::DATA_W-1:0]       i_pwdata,
  input logic                             i_pwrite,
  input logic                             i_psel,
  input logic                             i_penable,
  input logic [cnt_pkg::DATA_W-1:0]       i_prdata,
  input logic [cnt_pkg::COUNTER_NUM-1:0]  i_wave,
  input logic                             i_int
);
  import cnt_pkg::*;

  string            test_name = "none";
  int               err_cnt = 0;
  int               chk_cnt = 0;
  int               wave_toggles [COUNTER_NUM];
  logic             sh_mode   [COUNTER_NUM];
  logic [CNT_W-1:0] sh_target [COUNTER_NUM];
  logic [COUNTER_NUM-1:0] sh_mask;
  logic [COUNTER_NUM-1:0] wave_prev;

  // address of a register inside a channel block
  function automatic logic [31:0] blk_addr(input int ch, input logic [31:0] ofs);
    blk_addr = 32'h10 + 32'h10 * ch + ofs;
  endfunction

  // expected read value from the shadow copy
  function automatic logic [31:0] ref_value(input logic [31:0] a);
    ref_value = '0;
    if (a == 32'h08) ref_value = 32'(sh_mask);
    for (int ch = 0; ch < COUNTER_NUM; ch++) begin
      if (a == blk_addr(ch, 32'h0)) ref_value = {31'd0, sh_mode[ch]};
      if (a == blk_addr(ch, 32'h4)) ref_value = sh_target[ch];
    end
  endfunction

  // bits that the shadow can predict
  function automatic logic [31:0] ref_care(input logic [31:0] a);
    ref_care = '1;
    // status bits depend on channel activity
    if (a == 32'h04) ref_care = ~32'hF;
    for (int ch = 0; ch < COUNTER_NUM; ch++) begin
      // state field is live
      if (a == blk_addr(ch, 32'h0)) ref_care = ~32'h300;
      if (a == blk_addr(ch, 32'h8)) ref_care = '0;
    end
  endfunction

  function automatic void check_eq(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endfunction

  function automatic void check_cond(input bit ok, input string text);
    chk_cnt++;
    if (!ok) begin
      err_cnt++;
      $display("error in %s: %s", test_name, text);
    end
  endfunction

  // shadow follows writes at the setup edge
  always @(posedge i_pclk or negedge i_prst_n) begin
    if (!i_prst_n) begin
      sh_mask <= '0;
      for (int ch = 0; ch < COUNTER_NUM; ch++) begin
        sh_mode[ch]   <= 1'b0;
        sh_target[ch] <= '0;
      end
    end else if (i_psel && i_pwrite && !i_penable) begin
      if (i_paddr == 32'h08) sh_mask <= i_pwdata[COUNTER_NUM-1:0];
      for (int ch = 0; ch < COUNTER_NUM; ch++) begin
        if (i_paddr == blk_addr(ch, 32'h0)) sh_mode[ch] <= i_pwdata[0];
        if (i_paddr == blk_addr(ch, 32'h4)) sh_target[ch] <= i_pwdata;
      end
    end
  end

  // read data is stable in the access phase
  always @(negedge i_pclk) begin
    // count reads carry no predictable bits
    if (i_prst_n && i_psel && i_penable && !i_pwrite && ref_care(i_paddr) != '0) begin
      check_eq($sformatf("read %h", i_paddr), ref_value(i_paddr) & ref_care(i_paddr),
               i_prdata & ref_care(i_paddr));
    end
    // no interrupt can come through an empty mask
    if (i_prst_n && i_int && sh_mask == '0) begin
      check_cond(1'b0, "interrupt high with all channels masked");
    end
  end

  // wave edges per channel
  always @(negedge i_pclk) begin
    if (!i_prst_n) begin
      wave_prev = '0;
      for (int ch = 0; ch < COUNTER_NUM; ch++) wave_toggles[ch] = 0;
    end else begin
      for (int ch = 0; ch < COUNTER_NUM; ch++) begin
        if (i_wave[ch] != wave_prev[ch]) wave_toggles[ch]++;
      end
      wave_prev = i_wave;
    end
  end

endmodule

/* verification/tb_cnt_top.sv */
`timescale 1ns/1ps

module tb_cnt_top;
  import cnt_pkg::*;

  logic                   pclk;
  logic                   prst_n;
  logic [ADDR_W-1:0]      paddr;
  logic [DATA_W-1:0]      pwdata;
  logic                   pwrite;
  logic                   psel;
  logic                   penable;
  logic [DATA_W-1:0]      prdata;
  logic [COUNTER_NUM-1:0] wave;
  logic                   intr;
  logic [31:0]            rd;
  logic [31:0]            rd2;
  logic [31:0]            tgt;
  int                     n;

  tb_clk_gen u_clk (.o_clk(pclk), .o_rst_n(prst_n));

  cnt_top DUT (
    .i_pclk(pclk), .i_prst_n(prst_n), .i_paddr(paddr), .i_pwdata(pwdata),
    .i_pwrite(pwrite), .i_psel(psel), .i_penable(penable), .o_prdata(prdata),
    .o_wave(wave), .o_int(intr)
  );

  tb_cnt_checker u_checker (
    .i_pclk(pclk), .i_prst_n(prst_n), .i_paddr(paddr), .i_pwdata(pwdata),
    .i_pwrite(pwrite), .i_psel(psel), .i_penable(penable), .i_prdata(prdata),
    .i_wave(wave), .i_int(intr)
  );

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge pclk);
    psel    <= 1'b1;
    pwrite  <= 1'b1;
    penable <= 1'b0;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge pclk);
    penable <= 1'b1;
    @(posedge pclk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge pclk);
    psel    <= 1'b1;
    pwrite  <= 1'b0;
    penable <= 1'b0;
    paddr   <= addr;
    @(posedge pclk);
    penable <= 1'b1;
    @(posedge pclk);
    // prdata only moves on a setup edge
    data = prdata;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // poll the ctrl state field until it reaches st
  task automatic wait_state(input int ch, input logic [1:0] st, input int max_reads);
    logic [31:0] v;
    int k;
    k = 0;
    v = '0;
    while (k < max_reads) begin
      apb_read(ch_addr(ch, OFS_CTRL), v);
      if (v[9:8] == st) break;
      k++;
    end
    if (k == max_reads) u_checker.check_cond(1'b0, "channel state never reached");
  endtask

  task automatic wait_toggles(input int ch, input int cnt, input int max_cycles);
    int start;
    int k;
    start = u_checker.wave_toggles[ch];
    k = 0;
    while (u_checker.wave_toggles[ch] - start < cnt && k < max_cycles) begin
      @(posedge pclk);
      k++;
    end
    if (u_checker.wave_toggles[ch] - start < cnt) begin
      u_checker.check_cond(1'b0, "wave output stopped toggling");
    end
  endtask

  task automatic check_int(input logic exp);
    @(negedge pclk);
    u_checker.check_eq("o_int", 32'(exp), 32'(intr));
  endtask

  // hard limit on the whole run
  initial begin
    #400000;
    $display("simulation did not finish in time");
    $display("tests failed");
    $finish;
  end

  initial begin
    paddr   = '0;
    pwdata  = '0;
    pwrite  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    void'($urandom(32'h522405df));
    n = 0;
    while (prst_n !== 1'b1 && n < 100) begin
      @(posedge pclk);
      n++;
    end
    if (prst_n !== 1'b1) u_checker.check_cond(1'b0, "reset never released");

    u_checker.test_name = "reset";
    apb_read(ADDR_GLOBAL_CMD, rd);
    apb_read(ADDR_INTR_STATUS, rd);
    u_checker.check_eq("status", 0, rd);
    apb_read(ADDR_INTR_MASK, rd);
    for (int ch = 0; ch < COUNTER_NUM; ch++) begin
      apb_read(ch_addr(ch, OFS_CTRL), rd);
      u_checker.check_eq("ctrl", 0, rd);
      apb_read(ch_addr(ch, OFS_TARGET), rd);
      apb_read(ch_addr(ch, OFS_COUNT), rd);
      u_checker.check_eq("count", 0, rd);
    end
    check_int(1'b0);
    u_checker.check_eq("o_wave", 0, 32'(wave));

    // checker compares the random configuration readback
    u_checker.test_name = "config";
    for (int ch = 0; ch < COUNTER_NUM; ch++) begin
      apb_write(ch_addr(ch, OFS_CTRL), $urandom & 32'h1);
      apb_write(ch_addr(ch, OFS_TARGET), $urandom);
      apb_read(ch_addr(ch, OFS_CTRL), rd);
      apb_read(ch_addr(ch, OFS_TARGET), rd);
    end
    apb_write(ADDR_INTR_MASK, $urandom & 32'hF);
    apb_read(ADDR_INTR_MASK, rd);
    apb_write(ADDR_INTR_MASK, 0);

    u_checker.test_name = "oneshot";
    tgt = 2 + $urandom % 199;
    apb_write(ch_addr(0, OFS_CTRL), 32'(MODE_ONESHOT));
    apb_write(ch_addr(0, OFS_TARGET), tgt);
    apb_write(ch_addr(0, OFS_CMD), 32'(CMD_CLEAR));
    apb_write(ch_addr(0, OFS_CMD), 32'(CMD_START));
    wait_state(0, ST_DONE, 200);
    apb_read(ch_addr(0, OFS_COUNT), rd);
    u_checker.check_eq("count", tgt, rd);
    apb_read(ch_addr(0, OFS_COUNT), rd);
    u_checker.check_eq("count again", tgt, rd);
    apb_read(ADDR_INTR_STATUS, rd);
    u_checker.check_eq("status bit 0", 1, 32'(rd[0]));

    u_checker.test_name = "periodic";
    tgt = 2 + $urandom % 39;
    apb_write(ch_addr(1, OFS_CTRL), 32'(MODE_PERIODIC));
    apb_write(ch_addr(1, OFS_TARGET), tgt);
    apb_write(ch_addr(1, OFS_CMD), 32'(CMD_CLEAR));
    apb_write(ch_addr(1, OFS_CMD), 32'(CMD_START));
    for (int k = 0; k < 8; k++) begin
      apb_read(ch_addr(1, OFS_COUNT), rd);
      u_checker.check_cond(rd <= tgt, $sformatf("count %0d above target %0d", rd, tgt));
    end
    wait_toggles(1, 2, 1000);

    u_checker.test_name = "interrupt";
    check_int(1'b0);
    apb_write(ADDR_INTR_MASK, 32'h1);
    check_int(1'b1);
    apb_write(ADDR_INTR_STATUS, 32'h1);
    check_int(1'b0);
    apb_read(ADDR_INTR_STATUS, rd);
    u_checker.check_eq("status bit 0", 0, 32'(rd[0]));
    apb_write(ADDR_INTR_MASK, 32'h2);
    check_int(1'b1);
    apb_write(ADDR_INTR_MASK, 32'h0);
    check_int(1'b0);

    u_checker.test_name = "global";
    for (int ch = 0; ch < COUNTER_NUM; ch++) begin
      apb_write(ch_addr(ch, OFS_CTRL), 32'(MODE_PERIODIC));
      apb_write(ch_addr(ch, OFS_TARGET), 1000);
    end
    apb_write(ADDR_GLOBAL_CMD, 32'(CMD_START));
    apb_write(ADDR_GLOBAL_CMD, 32'(CMD_STOP));
    for (int ch = 0; ch < COUNTER_NUM; ch++) begin
      apb_read(ch_addr(ch, OFS_COUNT), rd);
      apb_read(ch_addr(ch, OFS_COUNT), rd2);
      u_checker.check_eq("stopped count", rd, rd2);
    end
    apb_write(ADDR_GLOBAL_CMD, 32'(CMD_CLEAR));
    for (int ch = 0; ch < COUNTER_NUM; ch++) begin
      apb_read(ch_addr(ch, OFS_COUNT), rd);
      u_checker.check_eq("cleared count", 0, rd);
    end
    apb_write(ADDR_GLOBAL_CMD, 32'(CMD_START));
    for (int ch = 0; ch < COUNTER_NUM; ch++) begin
      apb_read(ch_addr(ch, OFS_COUNT), rd);
      apb_read(ch_addr(ch, OFS_COUNT), rd2);
      u_checker.check_cond(rd != rd2, $sformatf("channel %0d count not moving", ch));
    end

    $display("checks %0d errors %0d", u_checker.chk_cnt, u_checker.err_cnt);
    if (u_checker.err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
